/* files.f */
+incdir+hw
hw/ee_state_pkg.sv
hw/ee_cmd_pkg.sv
hw/ee_ctrl_fsm.sv
hw/ee_bit_addr_counter.sv
hw/ee_cmd_reg.sv
hw/ee_data_reg.sv
hw/ee_mem_array.sv
hw/ee_serial_eeprom.sv
test/tb_ee_serial_eeprom.sv

/* Bender.yml */
package:
  name: ee_serial_eeprom

export_include_dirs:
  - hw

sources:
  - hw/ee_state_pkg.sv
  - hw/ee_cmd_pkg.sv
  - hw/ee_ctrl_fsm.sv
  - hw/ee_bit_addr_counter.sv
  - hw/ee_cmd_reg.sv
  - hw/ee_data_reg.sv
  - hw/ee_mem_array.sv
  - hw/ee_serial_eeprom.sv
  - target: test
    files:
      - test/tb_ee_serial_eeprom.sv

/* test/tb_ee_serial_eeprom.sv */
// Testbench of the 93C46-style serial EEPROM
// Bit-bangs random commands on CS, SK and DI and checks DO against a word model
// Top module tb_ee_serial_eeprom, sources from files.f

module tb_ee_serial_eeprom;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_CMDS    = 200;
	localparam int POLL_MAX    = 200; // Clocks allowed for one busy phase
	localparam int CYCLE_LIMIT = NUM_CMDS * (26 * 8 + 150) + 1000;

	typedef enum {C_READ, C_WRITE, C_ERASE, C_EWEN, C_EWDS, C_ERAL, C_WRAL} cmd_kind_e;

	logic sys_clk, xresetl;
	logic ee_cs, ee_sk, ee_di, ee_do;
	logic [15:0] model_mem [64]; // Expected array contents
	logic model_we;              // Expected write-enable latch
	int errors, checks, cycle_cnt;
	int unsigned seed_val;

	ee_serial_eeprom dut_i (
		.sys_clk, .xresetl, .ee_cs_i(ee_cs), .ee_sk_i(ee_sk), .ee_di_i(ee_di), .ee_do_o(ee_do)
	);

	always #20 sys_clk = ~sys_clk; // 40 ns period

	// Run limit
	always @(posedge sys_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("Timeout: run still going after %0d clocks", CYCLE_LIMIT);
			$display("TB FAILED");
			$finish;
		end
	end

	// Wait n rising edges, then the drive offset
	task automatic step(input int n);
		repeat (n) @(posedge sys_clk);
		#2;
	endtask

	task automatic check_do(input logic exp, input string what);
		checks++;
		if (ee_do !== exp) begin
			errors++;
			$display("** Error at %0t: %s, DO %b expected %b", $time, what, ee_do, exp);
		end
	endtask

	task automatic raise_sk(input logic b);
		ee_di = b; // Stable for the whole SK high phase
		ee_sk = 1'b1;
		step(4);
	endtask

	task automatic drop_sk;
		ee_sk = 1'b0;
		step(4);
	endtask

	task automatic send_bit(input logic b);
		raise_sk(b);
		drop_sk();
	endtask

	// Start bit, op field, address; extended ops put the sub-op in bits 5:4
	function automatic logic [8:0] encode_instr(input cmd_kind_e kind, input logic [5:0] addr);
		case (kind)
			C_READ:  return {1'b1, 2'b10, addr};
			C_WRITE: return {1'b1, 2'b01, addr};
			C_ERASE: return {1'b1, 2'b11, addr};
			C_EWEN:  return {1'b1, 2'b00, 2'b11, addr[3:0]}; // Low bits are don't care
			C_EWDS:  return {1'b1, 2'b00, 2'b00, addr[3:0]};
			C_ERAL:  return {1'b1, 2'b00, 2'b10, addr[3:0]};
			default: return {1'b1, 2'b00, 2'b01, addr[3:0]}; // WRAL
		endcase
	endfunction

	// Mostly READ and WRITE, writes usually enabled
	function automatic cmd_kind_e pick_kind();
		int r;
		r = $urandom_range(0, 99);
		if (r < 38) return C_READ;
		if (r < 68) return C_WRITE;
		if (r < 76) return C_ERASE;
		if (r < 84) return C_EWEN;
		if (r < 89) return C_EWDS;
		if (r < 94) return C_ERAL;
		return C_WRAL;
	endfunction

	// SK still high from the last bit
	task automatic wait_ready;
		int polls;
		polls = 0;
		if (model_we)
			check_do(1'b0, "no busy after the last bit");
		while (ee_do !== 1'b1 && polls < POLL_MAX) begin
			step(1);
			polls++;
		end
		if (ee_do !== 1'b1) begin
			errors++;
			$display("Stuck write: DO still low %0d clocks after the last bit, at %0t",
				POLL_MAX, $time);
		end
	endtask

	task automatic read_word(input logic [5:0] addr);
		logic [15:0] got;
		got = '0;
		check_do(1'b0, "dummy bit before read data");
		for (int i = 0; i < 16; i++) begin
			send_bit(1'b0);
			got = {got[14:0], ee_do}; // MSB first
		end
		checks++;
		if (got !== model_mem[addr]) begin
			errors++;
			$display("** Error at %0t: READ addr %0d got %h expected %h",
				$time, addr, got, model_mem[addr]);
		end
	endtask

	task automatic update_model(input cmd_kind_e kind, input logic [5:0] addr,
		input logic [15:0] data);
		case (kind)
			C_EWEN:  model_we = 1'b1;
			C_EWDS:  model_we = 1'b0;
			C_WRITE: if (model_we) model_mem[addr] = data;
			C_ERASE: if (model_we) model_mem[addr] = 16'hffff;
			C_ERAL:  if (model_we) for (int i = 0; i < 64; i++) model_mem[i] = 16'hffff;
			C_WRAL:  if (model_we) for (int i = 0; i < 64; i++) model_mem[i] = data;
			default: ; // READ leaves contents alone
		endcase
	endtask

	// One command framed by CS
	task automatic run_cmd(input cmd_kind_e kind, input logic [5:0] addr,
		input logic [15:0] data);
		logic [24:0] stream;
		int n_bits;
		logic writes;
		stream = {encode_instr(kind, addr), data};
		n_bits = (kind == C_WRITE || kind == C_WRAL) ? 25 : 9;
		writes = (kind == C_WRITE) || (kind == C_ERASE) || (kind == C_ERAL) || (kind == C_WRAL);
		ee_cs = 1'b1;
		step(4);
		for (int i = 24; i > 25 - n_bits; i--)
			send_bit(stream[i]);
		if (writes) begin
			raise_sk(stream[25 - n_bits]); // Last bit starts the write
			wait_ready();
			drop_sk();
		end else begin
			send_bit(stream[25 - n_bits]);
		end
		if (kind == C_READ)
			read_word(addr);
		update_model(kind, addr, data);
		ee_cs = 1'b0;
		step(4);
		check_do(1'b1, "DO not high after CS drop");
	endtask

	initial begin
		cmd_kind_e kind;
		logic [5:0] addr;
		logic [15:0] data;
		sys_clk   = 1'b0;
		xresetl   = 1'b0;
		ee_cs     = 1'b0;
		ee_sk     = 1'b0;
		ee_di     = 1'b0;
		model_we  = 1'b0;
		errors    = 0;
		checks    = 0;
		cycle_cnt = 0;
		seed_val  = $urandom(32'h044d_ad8d); // Seed once
		step(16);
		xresetl = 1'b1;
		step(1);
		check_do(1'b1, "DO not high after reset");
		// Known contents before random traffic
		run_cmd(C_EWEN, 6'd0, 16'h0000);
		run_cmd(C_ERAL, 6'd0, 16'h0000);
		for (int n = 2; n < NUM_CMDS; n++) begin
			kind = pick_kind();
			addr = 6'($urandom_range(0, 63));
			data = 16'($urandom);
			run_cmd(kind, addr, data);
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* hw/ee_serial_eeprom.sv */
// Top level of the 93C46-style serial configuration EEPROM
// Pins CS, SK, DI in and DO out, sampled in the sys_clk domain
// Connects sequencer, counters, shift registers and the array

module ee_serial_eeprom (
	input  logic sys_clk,
	input  logic xresetl,
	input  logic ee_cs_i,
	input  logic ee_sk_i,
	input  logic ee_di_i,
	output logic ee_do_o
);

	logic clr, cmd_shift, din_shift, rd_load, rd_shift;
	logic bits_clr, bits_inc, addr_load, addr_inc;
	logic mem_we, busy_set, ready_set, fill_ones;
	logic cmd_done, last_bit, last_addr;
	ee_cmd_pkg::ee_op_e   op;
	ee_cmd_pkg::ee_addr_t cmd_addr, wr_addr;
	ee_cmd_pkg::ee_word_t wr_data, rd_data;

	ee_ctrl_fsm u_fsm (
		.sys_clk, .xresetl, .cs_i(ee_cs_i), .sk_i(ee_sk_i),
		.cmd_done_i(cmd_done), .op_i(op), .last_bit_i(last_bit), .last_addr_i(last_addr),
		.clr_o(clr), .cmd_shift_o(cmd_shift), .din_shift_o(din_shift),
		.rd_load_o(rd_load), .rd_shift_o(rd_shift), .bits_clr_o(bits_clr),
		.bits_inc_o(bits_inc), .addr_load_o(addr_load), .addr_inc_o(addr_inc),
		.mem_we_o(mem_we), .busy_set_o(busy_set), .ready_set_o(ready_set),
		.fill_ones_o(fill_ones)
	);

	ee_bit_addr_counter u_cnt (
		.sys_clk, .xresetl, .bits_clr_i(bits_clr), .bits_inc_i(bits_inc),
		.addr_load_i(addr_load), .addr_inc_i(addr_inc), .load_addr_i(cmd_addr),
		.wr_addr_o(wr_addr), .last_bit_o(last_bit), .last_addr_o(last_addr)
	);

	ee_cmd_reg u_cmd (
		.sys_clk, .xresetl, .clr_i(clr), .shift_i(cmd_shift), .din_i(ee_di_i),
		.cmd_done_o(cmd_done), .op_o(op), .cmd_addr_o(cmd_addr)
	);

	ee_data_reg u_data (
		.sys_clk, .xresetl, .clr_i(clr), .din_shift_i(din_shift), .din_i(ee_di_i),
		.rd_load_i(rd_load), .rd_data_i(rd_data), .rd_shift_i(rd_shift),
		.busy_set_i(busy_set), .ready_set_i(ready_set), .fill_ones_i(fill_ones),
		.wr_data_o(wr_data), .dout_o(ee_do_o)
	);

	ee_mem_array u_mem (
		.sys_clk, .we_i(mem_we), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
		.rd_addr_i(cmd_addr), .rd_data_o(rd_data)
	);

endmodule

/* hw/ee_mem_array.sv */
// Storage array of the serial EEPROM, 64 words of 16 bits
// Combinational read port, write on the clock edge with we_i
`include "eeprom_cfg.svh"

module ee_mem_array (
	input  logic                 sys_clk,
	input  logic                 we_i,
	input  ee_cmd_pkg::ee_addr_t wr_addr_i,
	input  ee_cmd_pkg::ee_word_t wr_data_i,
	input  ee_cmd_pkg::ee_addr_t rd_addr_i,
	output ee_cmd_pkg::ee_word_t rd_data_o
);

	// Contents undefined until written
	ee_cmd_pkg::ee_word_t mem_q [`EE_WORDS];

	always_ff @(posedge sys_clk) begin
		if (we_i)
			mem_q[wr_addr_i] <= wr_data_i;
	end

	// Read address comes straight from the instruction
	assign rd_data_o = mem_q[rd_addr_i];

endmodule

/* hw/ee_data_reg.sv */
// Data shift register and serial output bit
// Shifts write data in, or takes a word from the array and shifts it out
// MSB first. The output bit also signals busy (0) and ready (1).
`include "eeprom_cfg.svh"

module ee_data_reg (
	input  logic                 sys_clk,
	input  logic                 xresetl,
	input  logic                 clr_i,
	input  logic                 din_shift_i,
	input  logic                 din_i,
	input  logic                 rd_load_i,
	input  ee_cmd_pkg::ee_word_t rd_data_i,
	input  logic                 rd_shift_i,
	input  logic                 busy_set_i,
	input  logic                 ready_set_i,
	input  logic                 fill_ones_i,
	output ee_cmd_pkg::ee_word_t wr_data_o,
	output logic                 dout_o
);

	ee_cmd_pkg::ee_word_t dr_q;

	always_ff @(posedge sys_clk) begin
		if (rd_load_i)
			dr_q <= rd_data_i;
		else if (din_shift_i)
			dr_q <= {dr_q[`EE_DATA_W-2:0], din_i};
		else if (rd_shift_i)
			dr_q <= {dr_q[`EE_DATA_W-2:0], 1'b0};
	end

	always_ff @(posedge sys_clk) begin
		if (!xresetl)
			dout_o <= 1'b1; // Idle high
		else if (clr_i || ready_set_i)
			dout_o <= 1'b1;
		else if (rd_load_i || busy_set_i)
			dout_o <= 1'b0; // Dummy bit, or busy
		else if (rd_shift_i)
			dout_o <= dr_q[`EE_DATA_W-1]; // Present current MSB
	end

	assign wr_data_o = fill_ones_i ? '1 : dr_q; // ERASE and ERAL write FFFF

	// Read load settles a full cycle before any shift
	a_load_no_shift: assert property (@(posedge sys_clk) disable iff (!xresetl)
		rd_load_i |-> !(din_shift_i || rd_shift_i) ##1 !rd_shift_i);

endmodule

/* hw/ee_cmd_reg.sv */
// Instruction shift register and opcode decode
// Shifts start bit, op field and address MSB first. Zeros ahead of the start
// bit fall off the top. Done once the start bit reaches the top bit.
`include "eeprom_cfg.svh"

module ee_cmd_reg (
	input  logic                 sys_clk,
	input  logic                 xresetl,
	input  logic                 clr_i,
	input  logic                 shift_i,
	input  logic                 din_i,
	output logic                 cmd_done_o,
	output ee_cmd_pkg::ee_op_e   op_o,
	output ee_cmd_pkg::ee_addr_t cmd_addr_o
);

	logic [`EE_CMD_W-1:0] ir_q;
	logic [1:0] op_field, ext_field;

	always_ff @(posedge sys_clk) begin
		if (!xresetl || clr_i)
			ir_q <= '0; // CS low starts a fresh instruction
		else if (shift_i)
			ir_q <= {ir_q[`EE_CMD_W-2:0], din_i};
	end

	assign cmd_done_o = ir_q[`EE_CMD_W-1];
	assign op_field   = ir_q[`EE_CMD_W-2 -: 2];
	assign ext_field  = ir_q[`EE_ADDR_W-1 -: 2];

	// Extended ops carry the sub-op in the address field, sweeps begin at 0
	assign cmd_addr_o = (op_field == ee_cmd_pkg::OPF_EXT) ? '0 : ir_q[`EE_ADDR_W-1:0];

	always_comb begin
		op_o = ee_cmd_pkg::OP_NONE;
		if (cmd_done_o) begin
			case (op_field)
				ee_cmd_pkg::OPF_READ:  op_o = ee_cmd_pkg::OP_READ;
				ee_cmd_pkg::OPF_WRITE: op_o = ee_cmd_pkg::OP_WRITE;
				ee_cmd_pkg::OPF_ERASE: op_o = ee_cmd_pkg::OP_ERASE;
				default: begin
					case (ext_field)
						ee_cmd_pkg::EXT_EWEN: op_o = ee_cmd_pkg::OP_EWEN;
						ee_cmd_pkg::EXT_ERAL: op_o = ee_cmd_pkg::OP_ERAL;
						ee_cmd_pkg::EXT_WRAL: op_o = ee_cmd_pkg::OP_WRAL;
						default:              op_o = ee_cmd_pkg::OP_EWDS;
					endcase
				end
			endcase
		end
	end

endmodule

/* hw/ee_bit_addr_counter.sv */
// Data bit counter and write address counter
// Counts the 16 bits of WRITE and WRAL data, holds the write address
// and steps it through the array for ERAL and WRAL
`include "eeprom_cfg.svh"

module ee_bit_addr_counter (
	input  logic                 sys_clk,
	input  logic                 xresetl,
	input  logic                 bits_clr_i,
	input  logic                 bits_inc_i,
	input  logic                 addr_load_i,
	input  logic                 addr_inc_i,
	input  ee_cmd_pkg::ee_addr_t load_addr_i,
	output ee_cmd_pkg::ee_addr_t wr_addr_o,
	output logic                 last_bit_o,
	output logic                 last_addr_o
);

	logic [`EE_CNT_W-1:0] bit_cnt_q;

	always_ff @(posedge sys_clk) begin
		if (!xresetl) begin
			bit_cnt_q <= '0;
			wr_addr_o <= '0;
		end else begin
			if (bits_clr_i)
				bit_cnt_q <= '0;
			else if (bits_inc_i)
				bit_cnt_q <= bit_cnt_q + 1'b1; // Wraps after the 16th bit
			if (addr_load_i)
				wr_addr_o <= load_addr_i;
			else if (addr_inc_i)
				wr_addr_o <= wr_addr_o + 1'b1;
		end
	end

	assign last_bit_o  = &bit_cnt_q; // Next bit is the last one
	assign last_addr_o = &wr_addr_o; // Top word of the array

	// Sweep ends on the top word, never wraps back to 0
	a_no_addr_wrap: assert property (@(posedge sys_clk) disable iff (!xresetl)
		addr_inc_i |-> !last_addr_o);

endmodule

/* hw/ee_ctrl_fsm.sv */
// Control sequencer of the serial EEPROM
// Detects SK rising edges, dispatches decoded instructions, runs the write
// sequence and holds the write-enable latch. All outputs are one-cycle strobes.

module ee_ctrl_fsm (
	input  logic               sys_clk,
	input  logic               xresetl,
	input  logic               cs_i,
	input  logic               sk_i,
	input  logic               cmd_done_i,
	input  ee_cmd_pkg::ee_op_e op_i,
	input  logic               last_bit_i,
	input  logic               last_addr_i,
	output logic               clr_o,
	output logic               cmd_shift_o,
	output logic               din_shift_o,
	output logic               rd_load_o,
	output logic               rd_shift_o,
	output logic               bits_clr_o,
	output logic               bits_inc_o,
	output logic               addr_load_o,
	output logic               addr_inc_o,
	output logic               mem_we_o,
	output logic               busy_set_o,
	output logic               ready_set_o,
	output logic               fill_ones_o
);

	ee_state_pkg::ee_state_e state_q, state_d;
	logic sk_sync_q, sk_prev_q;
	logic sk_rise;
	logic wel_q, wel_set, wel_clr; // Write-enable latch
	logic sweep, erase_op;

	assign sk_rise = sk_sync_q & ~sk_prev_q;
	assign sweep = (op_i == ee_cmd_pkg::OP_ERAL) || (op_i == ee_cmd_pkg::OP_WRAL);
	assign erase_op = (op_i == ee_cmd_pkg::OP_ERASE) || (op_i == ee_cmd_pkg::OP_ERAL);

	always_ff @(posedge sys_clk) begin
		if (!xresetl) begin
			state_q   <= ee_state_pkg::ST_IDLE;
			sk_sync_q <= 1'b0;
			sk_prev_q <= 1'b0;
			wel_q     <= 1'b0; // Writes locked until EWEN
		end else begin
			sk_sync_q <= sk_i;
			sk_prev_q <= sk_sync_q;
			state_q   <= state_d;
			if (wel_set)
				wel_q <= 1'b1;
			else if (wel_clr)
				wel_q <= 1'b0;
		end
	end

	always_comb begin
		state_d     = state_q;
		clr_o       = 1'b0;
		cmd_shift_o = 1'b0;
		din_shift_o = 1'b0;
		rd_load_o   = 1'b0;
		rd_shift_o  = 1'b0;
		bits_clr_o  = 1'b0;
		bits_inc_o  = 1'b0;
		addr_load_o = 1'b0;
		addr_inc_o  = 1'b0;
		mem_we_o    = 1'b0;
		busy_set_o  = 1'b0;
		ready_set_o = 1'b0;
		fill_ones_o = 1'b0;
		wel_set     = 1'b0;
		wel_clr     = 1'b0;
		if (!cs_i) begin
			clr_o   = 1'b1; // Abort, output back high
			state_d = ee_state_pkg::ST_IDLE;
		end else begin
			case (state_q)
				ee_state_pkg::ST_IDLE: begin
					if (cmd_done_i) begin
						case (op_i)
							ee_cmd_pkg::OP_READ: begin
								rd_load_o = 1'b1; // Word out of array, dummy 0
								state_d   = ee_state_pkg::ST_READ;
							end
							ee_cmd_pkg::OP_WRITE, ee_cmd_pkg::OP_WRAL: begin
								bits_clr_o = 1'b1;
								state_d    = ee_state_pkg::ST_DATA;
							end
							ee_cmd_pkg::OP_ERASE, ee_cmd_pkg::OP_ERAL:
								state_d = ee_state_pkg::ST_WR_BEGIN;
							ee_cmd_pkg::OP_EWEN: begin
								wel_set = 1'b1;
								state_d = ee_state_pkg::ST_HOLD;
							end
							ee_cmd_pkg::OP_EWDS: begin
								wel_clr = 1'b1;
								state_d = ee_state_pkg::ST_HOLD;
							end
							default: state_d = ee_state_pkg::ST_HOLD;
						endcase
					end else if (sk_rise) begin
						cmd_shift_o = 1'b1;
					end
				end
				ee_state_pkg::ST_DATA: begin
					if (sk_rise) begin
						din_shift_o = 1'b1;
						bits_inc_o  = 1'b1;
						if (last_bit_i)
							state_d = ee_state_pkg::ST_WR_BEGIN; // 16th bit taken
					end
				end
				ee_state_pkg::ST_READ: rd_shift_o = sk_rise; // Runs until CS drops
				ee_state_pkg::ST_WR_BEGIN: begin
					busy_set_o  = 1'b1;
					addr_load_o = 1'b1; // Command address, 0 for sweeps
					state_d     = ee_state_pkg::ST_WR_WRITE;
				end
				ee_state_pkg::ST_WR_WRITE: begin
					mem_we_o    = wel_q; // Locked array sees no write
					fill_ones_o = erase_op;
					state_d     = ee_state_pkg::ST_WR_LOOP;
				end
				ee_state_pkg::ST_WR_LOOP: begin
					if (sweep && !last_addr_i) begin
						addr_inc_o = 1'b1;
						state_d    = ee_state_pkg::ST_WR_WRITE;
					end else begin
						state_d = ee_state_pkg::ST_WR_END;
					end
				end
				ee_state_pkg::ST_WR_END: begin
					ready_set_o = 1'b1;
					state_d     = ee_state_pkg::ST_HOLD;
				end
				default: state_d = state_q; // Hold until CS low
			endcase
		end
	end

	// Host keeps CS high through the busy phase, a drop aborts the write
	a_cs_held_write: assert property (@(posedge sys_clk) disable iff (!xresetl)
		state_q inside {ee_state_pkg::ST_WR_BEGIN, ee_state_pkg::ST_WR_WRITE,
			ee_state_pkg::ST_WR_LOOP, ee_state_pkg::ST_WR_END} |-> cs_i);

	// SK high for at least three samples, one rise per serial bit
	a_sk_high_held: assert property (@(posedge sys_clk) disable iff (!xresetl)
		sk_rise |-> sk_i ##1 sk_i);

endmodule

/* hw/ee_cmd_pkg.sv */
// Instruction encoding of the serial EEPROM
// Opcode enum, op field values and the address and word types
`include "eeprom_cfg.svh"

package ee_cmd_pkg;

	typedef logic [`EE_ADDR_W-1:0] ee_addr_t;
	typedef logic [`EE_DATA_W-1:0] ee_word_t;

	typedef enum logic [2:0] {
		OP_NONE, OP_READ, OP_WRITE, OP_ERASE, OP_EWEN, OP_EWDS, OP_ERAL, OP_WRAL
	} ee_op_e;

	localparam logic [1:0] OPF_READ  = 2'b10;
	localparam logic [1:0] OPF_WRITE = 2'b01;
	localparam logic [1:0] OPF_ERASE = 2'b11;
	localparam logic [1:0] OPF_EXT   = 2'b00; // Sub-op in address bits 5:4

	// Extended sub-op values, address bits 5:4
	localparam logic [1:0] EXT_EWEN = 2'b11;
	localparam logic [1:0] EXT_EWDS = 2'b00;
	localparam logic [1:0] EXT_ERAL = 2'b10;
	localparam logic [1:0] EXT_WRAL = 2'b01;

endpackage

/* hw/ee_state_pkg.sv */
// State encoding of the EEPROM control sequencer
// Referenced by scoped name from the sequencer

package ee_state_pkg;

	// Bit 2 set marks the internal write states
	typedef enum logic [2:0] {
		ST_IDLE     = 3'b000, // Shifting in the instruction
		ST_DATA     = 3'b001, // Shifting in 16 write data bits
		ST_READ     = 3'b010, // Shifting read data out
		ST_HOLD     = 3'b011, // Command over, wait for CS low
		ST_WR_BEGIN = 3'b100, // Go busy, load write address
		ST_WR_WRITE = 3'b101, // One word into the array
		ST_WR_LOOP  = 3'b110, // Next address or finish
		ST_WR_END   = 3'b111  // Back to ready
	} ee_state_e;

endpackage

/* hw/eeprom_cfg.svh */
// Size settings of the 93C46-style serial EEPROM model
// Include wherever an array, word, instruction or counter width is needed
// Guarded so that packages and modules can all include it

`ifndef EEPROM_CFG_SVH
`define EEPROM_CFG_SVH

`define EE_ADDR_W 6   // Word address bits
`define EE_WORDS 64   // Words in the array

`define EE_DATA_W 16  // Bits per data word

// Start bit, two op bits, address field
`define EE_CMD_W 9

`define EE_CNT_W 4    // Counts the 16 serial data bits

`endif
